/* rvDec_defines.svh */
// RISC-V decoder widths and ids
`ifndef RVDEC_DEFINES_SVH
`define RVDEC_DEFINES_SVH

`define RV_GPR_W 7
`define RV_IMM_W 33
`define RV_ISTR_W 32

// register field positions in the word
`define RV_RD_LSB 7
`define RV_RS1_LSB 15
`define RV_RS2_LSB 20

// special register ids, kept above the plain x8..x31 range
`define RV_GR_PC 7'h40
`define RV_GR_LR 7'h41
`define RV_GR_SP 7'h42
`define RV_GR_GBR 7'h43
`define RV_GR_TBR 7'h44
`define RV_GR_DHR 7'h45
`define RV_GR_DLR 7'h46
`define RV_GR_R7 7'h47
`define RV_GR_IMM 7'h5E
`define RV_GR_ZZR 7'h5F

`define RV_USER_TP 5'd4 // thread pointer, not writable from user mode

`endif

/* rvDecPkg.sv */
// RISC-V decoder types
`include "rvDec_defines.svh"

package rvDecPkg;

	// major micro-op
	typedef enum logic [5:0] {
		INVOP = 6'h00,
		MOV_MR = 6'h01,
		MOV_RM = 6'h02,
		JCMP = 6'h03,
		JSR = 6'h04,
		JMP = 6'h05,
		ALU3 = 6'h06,
		SHADQ3 = 6'h07,
		SHAD3 = 6'h08,
		LEA_MR = 6'h09,
		MOV_IR = 6'h0A
	} nmidT;

	// operand form
	typedef enum logic [4:0] {
		Z = 5'h00,
		INV = 5'h01,
		REGREG = 5'h02,
		REGIMMREG = 5'h03,
		LDREGDISPREG = 5'h04,
		REGSTREGDISP = 5'h05,
		IMM8REG = 5'h06,
		REGPC = 5'h07,
		PCDISP8 = 5'h08
	} fmidT;

	typedef enum logic [3:0] {
		SB = 4'h0,
		SW = 4'h1,
		UB = 4'h2
	} ityT;

	typedef enum logic [5:0] {
		ADD = 6'h00,
		SUB = 6'h01,
		ADDSL = 6'h02,
		SUBSL = 6'h03,
		SLTSQ = 6'h04,
		SLTUQ = 6'h05,
		SLTSL = 6'h06,
		SLTUL = 6'h07,
		XOR = 6'h08,
		OR = 6'h09,
		AND = 6'h0A,
		SHLDQ3 = 6'h10,
		SHLRQ3 = 6'h11,
		SHARQ3 = 6'h12,
		SHLD3 = 6'h13,
		SHLR3 = 6'h14,
		SHAR3 = 6'h15,
		QEQ = 6'h20,
		QNE = 6'h21,
		QLT = 6'h22,
		QGE = 6'h23,
		QBL = 6'h24,
		QHS = 6'h25,
		LDIX = 6'h30
	} ucixT;

	typedef enum logic [2:0] {
		SC = 3'h0,
		WX = 3'h1 // wide access, used for width code 7
	} uctyT;

	typedef struct packed {
		logic isRiscV;
		logic isWxe;
	} instrModeT;

	// plain ids and low-register ids per field
	typedef struct packed {
		logic [`RV_GPR_W-1:0] rdDfl;
		logic [`RV_GPR_W-1:0] rs1Dfl;
		logic [`RV_GPR_W-1:0] rs2Dfl;
		logic [`RV_GPR_W-1:0] rdMap;
		logic [`RV_GPR_W-1:0] rs1Map;
		logic [`RV_GPR_W-1:0] rs2Map;
		logic rdIsTp;
	} regFieldsT;

	typedef struct packed {
		logic [`RV_IMM_W-1:0] imm12s;
		logic [`RV_IMM_W-1:0] imm12u;
		logic [`RV_IMM_W-1:0] imm20Hi;
		logic [`RV_IMM_W-1:0] dispJ;
		logic [`RV_IMM_W-1:0] dispB;
		logic [`RV_IMM_W-1:0] dispS;
	} immSetT;

	typedef struct packed {
		nmidT nmid;
		fmidT fmid;
		ityT ity;
		logic [2:0] bty; // access width, funct3 of load and store
		ucixT ucmdIx;
		uctyT ucty;
		logic notFx;
	} opClassT;

	typedef struct packed {
		logic [2:0] ccty;
		nmidT nmid;
	} ucmdT;

	typedef struct packed {
		uctyT ucty;
		logic [5:0] ix;
	} uixtT;

	typedef struct packed {
		ucmdT uCmd;
		uixtT uIxt;
		logic [`RV_GPR_W-1:0] regN;
		logic [`RV_GPR_W-1:0] regM;
		logic [`RV_GPR_W-1:0] regO;
		logic [`RV_GPR_W-1:0] regP;
		logic [`RV_IMM_W-1:0] imm;
		logic [3:0] uFl;
	} microOpT;

endpackage

/* rvRegFieldMap.sv */
// register field mapping
`include "rvDec_defines.svh"

module rvRegFieldMap (
	input logic [`RV_ISTR_W-1:0] istrWord,
	output rvDecPkg::regFieldsT regs
);

	logic [4:0] rdF;
	logic [4:0] rs1F;
	logic [4:0] rs2F;

	// x0..x7 land on the core's special registers
	function automatic logic [`RV_GPR_W-1:0] lowReg(input logic [2:0] sel);
		logic [`RV_GPR_W-1:0] id;
		case (sel)
			3'd0: id = `RV_GR_ZZR;
			3'd1: id = `RV_GR_LR;
			3'd2: id = `RV_GR_SP;
			3'd3: id = `RV_GR_GBR;
			3'd4: id = `RV_GR_TBR;
			3'd5: id = `RV_GR_DHR;
			3'd6: id = `RV_GR_DLR;
			default: id = `RV_GR_R7;
		endcase
		return id;
	endfunction

	assign rdF = istrWord[`RV_RD_LSB +: 5];
	assign rs1F = istrWord[`RV_RS1_LSB +: 5];
	assign rs2F = istrWord[`RV_RS2_LSB +: 5];

	always_comb begin
		regs.rdDfl = {2'b00, rdF};
		regs.rs1Dfl = {2'b00, rs1F};
		regs.rs2Dfl = {2'b00, rs2F};
		regs.rdMap = lowReg(rdF[2:0]);
		regs.rs1Map = lowReg(rs1F[2:0]);
		regs.rs2Map = lowReg(rs2F[2:0]);
		regs.rdIsTp = (rdF == `RV_USER_TP); // feeds the user-mode reject
	end

endmodule

/* rvImmGen.sv */
// immediate generator
`include "rvDec_defines.svh"

module rvImmGen (
	input logic [`RV_ISTR_W-1:0] istrWord,
	output rvDecPkg::immSetT imms
);

	logic sgn;

	assign sgn = istrWord[31];

	always_comb begin
		// I-type, bits 31:20
		imms.imm12s = {{21{sgn}}, istrWord[31:20]};
		imms.imm12u = {21'h0, istrWord[31:20]};

		// U-type, top bit kept clear
		imms.imm20Hi = {1'b0, istrWord[31:12], 12'h000};

		// jal and branch displacements stay in halfword units
		imms.dispJ = {
			{14{sgn}},
			istrWord[19:12],
			istrWord[20],
			istrWord[30:21]
		};
		imms.dispB = {
			{22{sgn}},
			istrWord[7],
			istrWord[30:25],
			istrWord[11:8]
		};

		// S-type, split field
		imms.dispS = {{21{sgn}}, istrWord[31:25], istrWord[11:7]};
	end

endmodule

/* rvOpClassify.sv */
// opcode classifier
`include "rvDec_defines.svh"

module rvOpClassify (
	input logic [`RV_ISTR_W-1:0] istrWord,
	input rvDecPkg::instrModeT mode,
	output rvDecPkg::opClassT opClass
);

	logic [4:0] opc;
	logic [2:0] funct3;
	logic alt;
	logic rdZero;

	assign opc = istrWord[6:2];
	assign funct3 = istrWord[14:12];
	assign alt = istrWord[30]; // sub and arithmetic shift select
	assign rdZero = (istrWord[`RV_RD_LSB +: 5] == 5'd0);

	// shared table for OP, OP-IMM and the 32-bit variants
	function automatic void aluDecode(
		input logic [2:0] f3,
		input logic altSel,
		input logic isImm,
		input logic is32,
		output rvDecPkg::nmidT nm,
		output rvDecPkg::ucixT ix
	);
		nm = rvDecPkg::ALU3;
		ix = rvDecPkg::ADD;
		case (f3)
			3'b000: begin
				if (altSel && !isImm) // addi has no sub form
					ix = is32 ? rvDecPkg::SUBSL : rvDecPkg::SUB;
				else if (is32)
					ix = rvDecPkg::ADDSL;
			end
			3'b001: begin
				nm = is32 ? rvDecPkg::SHAD3 : rvDecPkg::SHADQ3;
				ix = is32 ? rvDecPkg::SHLD3 : rvDecPkg::SHLDQ3;
			end
			3'b010: ix = is32 ? rvDecPkg::SLTSL : rvDecPkg::SLTSQ;
			3'b011: ix = is32 ? rvDecPkg::SLTUL : rvDecPkg::SLTUQ;
			3'b100: ix = rvDecPkg::XOR;
			3'b101: begin
				nm = is32 ? rvDecPkg::SHAD3 : rvDecPkg::SHADQ3;
				if (altSel)
					ix = is32 ? rvDecPkg::SHAR3 : rvDecPkg::SHARQ3;
				else
					ix = is32 ? rvDecPkg::SHLR3 : rvDecPkg::SHLRQ3;
			end
			3'b110: ix = rvDecPkg::OR;
			default: ix = rvDecPkg::AND;
		endcase
	endfunction

	always_comb begin
		opClass.nmid = rvDecPkg::INVOP;
		opClass.fmid = rvDecPkg::INV;
		opClass.ity = rvDecPkg::SB;
		opClass.bty = 3'b000;
		opClass.ucmdIx = rvDecPkg::ADD;
		opClass.ucty = rvDecPkg::SC;
		opClass.notFx = (istrWord[1:0] != 2'b11) || mode.isWxe || !mode.isRiscV;

		case (opc)
			5'b00000: begin // LOAD
				opClass.nmid = rvDecPkg::MOV_MR;
				opClass.fmid = rvDecPkg::LDREGDISPREG;
				opClass.bty = funct3;
			end
			5'b01000: begin // STORE
				opClass.nmid = rvDecPkg::MOV_RM;
				opClass.fmid = rvDecPkg::REGSTREGDISP;
				opClass.bty = funct3;
			end
			5'b11000: begin // BRANCH
				opClass.nmid = rvDecPkg::JCMP;
				opClass.fmid = rvDecPkg::REGPC;
				opClass.ity = rvDecPkg::UB;
				case (funct3)
					3'b001: opClass.ucmdIx = rvDecPkg::QNE;
					3'b100: opClass.ucmdIx = rvDecPkg::QLT;
					3'b101: opClass.ucmdIx = rvDecPkg::QGE;
					3'b110: opClass.ucmdIx = rvDecPkg::QBL;
					3'b111: opClass.ucmdIx = rvDecPkg::QHS;
					default: opClass.ucmdIx = rvDecPkg::QEQ;
				endcase
			end
			5'b11001: begin // JALR
				opClass.nmid = rdZero ? rvDecPkg::JMP : rvDecPkg::JSR;
				opClass.fmid = rvDecPkg::REGIMMREG;
				opClass.ity = rvDecPkg::SW;
			end
			5'b11011: begin // JAL
				opClass.nmid = rdZero ? rvDecPkg::JMP : rvDecPkg::JSR;
				opClass.fmid = rvDecPkg::PCDISP8;
				opClass.ity = rvDecPkg::SW;
			end
			5'b00100: begin // OP-IMM
				opClass.fmid = rvDecPkg::REGIMMREG;
				opClass.ity = rvDecPkg::SW;
				aluDecode(funct3, alt, 1'b1, 1'b0, opClass.nmid, opClass.ucmdIx);
			end
			5'b01100: begin // OP
				opClass.fmid = rvDecPkg::REGREG;
				aluDecode(funct3, alt, 1'b0, 1'b0, opClass.nmid, opClass.ucmdIx);
			end
			5'b00110: begin // OP-IMM-32
				opClass.fmid = rvDecPkg::REGIMMREG;
				opClass.ity = rvDecPkg::SW;
				aluDecode(funct3, alt, 1'b1, 1'b1, opClass.nmid, opClass.ucmdIx);
			end
			5'b01110: begin // OP-32
				opClass.fmid = rvDecPkg::REGREG;
				aluDecode(funct3, alt, 1'b0, 1'b1, opClass.nmid, opClass.ucmdIx);
			end
			5'b00101: begin // AUIPC
				opClass.nmid = rvDecPkg::LEA_MR;
				opClass.fmid = rvDecPkg::PCDISP8;
			end
			5'b01101: begin // LUI
				opClass.nmid = rvDecPkg::MOV_IR;
				opClass.fmid = rvDecPkg::IMM8REG;
				opClass.ity = rvDecPkg::UB;
				opClass.ucmdIx = rvDecPkg::LDIX;
			end
			default: begin
			end
		endcase
	end

endmodule

/* rvOperandRoute.sv */
// operand routing
`include "rvDec_defines.svh"

module rvOperandRoute (
	input rvDecPkg::regFieldsT regs,
	input rvDecPkg::immSetT imms,
	input rvDecPkg::opClassT opClass,
	output rvDecPkg::microOpT rawOp,
	output logic rejectReq
);

	logic [`RV_GPR_W-1:0] rd;
	logic [`RV_GPR_W-1:0] rs1;
	logic [`RV_GPR_W-1:0] rs2;
	rvDecPkg::fmidT form;
	rvDecPkg::uctyT lsCty;
	logic [5:0] lsIx;

	// fields x0..x7 take the special id
	function automatic logic [`RV_GPR_W-1:0] pickId(
		input logic [`RV_GPR_W-1:0] dfl,
		input logic [`RV_GPR_W-1:0] low
	);
		return (dfl[`RV_GPR_W-1:3] == '0) ? low : dfl;
	endfunction

	assign rd = pickId(regs.rdDfl, regs.rdMap);
	assign rs1 = pickId(regs.rs1Dfl, regs.rs1Map);
	assign rs2 = pickId(regs.rs2Dfl, regs.rs2Map);

	// load and store index carries the access width
	assign lsIx = {opClass.bty[1:0], 1'b0, opClass.bty[2], 2'b00};

	assign rejectReq = regs.rdIsTp;

	always_comb begin
		if (opClass.notFx)
			form = rvDecPkg::Z;
		else
			form = opClass.fmid;

		lsCty = rvDecPkg::SC;
		if (opClass.bty == 3'b111)
			lsCty = rvDecPkg::WX;

		rawOp.uCmd.ccty = 3'b000; // always
		rawOp.uCmd.nmid = opClass.nmid;
		rawOp.uIxt.ucty = opClass.ucty;
		rawOp.uIxt.ix = opClass.ucmdIx;
		rawOp.regN = `RV_GR_ZZR;
		rawOp.regM = `RV_GR_ZZR;
		rawOp.regO = `RV_GR_ZZR;
		rawOp.regP = `RV_GR_ZZR;
		rawOp.imm = '0;
		rawOp.uFl = 4'h0;

		case (form)
			rvDecPkg::REGREG: begin
				rawOp.regN = rd;
				rawOp.regM = rs1;
				rawOp.regO = rs2;
				rawOp.regP = rd;
				rawOp.imm = imms.imm12u;
			end
			rvDecPkg::REGIMMREG: begin
				rawOp.regN = rd;
				rawOp.regM = rs1;
				rawOp.regO = `RV_GR_IMM;
				rawOp.regP = rd;
				rawOp.imm = imms.imm12s;
			end
			rvDecPkg::LDREGDISPREG: begin
				rawOp.regN = rd;
				rawOp.regM = rs1;
				rawOp.regO = `RV_GR_IMM;
				rawOp.regP = rd;
				rawOp.imm = imms.imm12u;
				rawOp.uIxt.ucty = lsCty;
				rawOp.uIxt.ix = lsIx;
			end
			rvDecPkg::REGSTREGDISP: begin
				rawOp.regN = rs2; // store data
				rawOp.regM = rs1;
				rawOp.regO = `RV_GR_IMM;
				rawOp.regP = rs2;
				rawOp.imm = imms.dispS;
				rawOp.uIxt.ucty = lsCty;
				rawOp.uIxt.ix = lsIx;
			end
			rvDecPkg::REGPC: begin
				if (opClass.ity == rvDecPkg::UB) begin
					rawOp.regM = rs1;
					rawOp.regO = rs2;
					rawOp.imm = imms.dispB;
				end else begin
					rawOp.uCmd.nmid = rvDecPkg::INVOP;
				end
			end
			rvDecPkg::PCDISP8: begin
				rawOp.regN = rd;
				rawOp.regM = `RV_GR_PC;
				rawOp.regO = `RV_GR_IMM;
				rawOp.regP = rd;
				if (opClass.ity == rvDecPkg::SB)
					rawOp.imm = imms.imm20Hi; // auipc
				else
					rawOp.imm = imms.dispJ;
			end
			rvDecPkg::IMM8REG: begin
				rawOp.regN = rd;
				rawOp.regM = `RV_GR_IMM;
				rawOp.regO = rd;
				rawOp.regP = rd;
				rawOp.imm = imms.imm20Hi;
			end
			default: begin
				// Z or unknown form
				rawOp.uCmd.nmid = rvDecPkg::INVOP;
				rawOp.uIxt = '0;
			end
		endcase
	end

endmodule

/* rvDecodeLatch.sv */
// privilege check and output register
`include "rvDec_defines.svh"

module rvDecodeLatch (
	input logic clock,
	input logic rst,
	input logic [2:0] srMod,
	input rvDecPkg::microOpT rawOp,
	input logic rejectReq,
	output rvDecPkg::microOpT decOp
);

	logic srUser;
	rvDecPkg::microOpT nextOp;

	assign srUser = srMod[0];

	// no allow level in user mode
	always_comb begin
		nextOp = rawOp;
		if (rejectReq && srUser)
			nextOp.uCmd.nmid = rvDecPkg::INVOP;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			decOp.uCmd.ccty <= 3'b000;
			decOp.uCmd.nmid <= rvDecPkg::INVOP;
			decOp.uIxt <= '0;
			decOp.regN <= `RV_GR_ZZR;
			decOp.regM <= `RV_GR_ZZR;
			decOp.regO <= `RV_GR_ZZR;
			decOp.regP <= `RV_GR_ZZR;
			decOp.imm <= '0;
			decOp.uFl <= 4'h0;
		end else begin
			decOp <= nextOp;
		end
	end

endmodule

/* rvDecTop.sv */
// RISC-V decoder top
`include "rvDec_defines.svh"

module rvDecTop (
	input logic clock,
	input logic rst,
	input logic [2:0] srMod,
	input logic [`RV_ISTR_W-1:0] istrWord,
	input rvDecPkg::instrModeT mode,
	output rvDecPkg::microOpT decOp
);

	rvDecPkg::regFieldsT regs;
	rvDecPkg::immSetT imms;
	rvDecPkg::opClassT opClass;
	rvDecPkg::microOpT rawOp;
	logic rejectReq;

	rvRegFieldMap u_regMap (
		.istrWord(istrWord),
		.regs(regs)
	);

	rvImmGen u_immGen (
		.istrWord(istrWord),
		.imms(imms)
	);

	rvOpClassify u_classify (
		.istrWord(istrWord),
		.mode(mode),
		.opClass(opClass)
	);

	rvOperandRoute u_route (
		.regs(regs),
		.imms(imms),
		.opClass(opClass),
		.rawOp(rawOp),
		.rejectReq(rejectReq)
	);

	// one cycle from word to micro-op
	rvDecodeLatch u_latch (
		.clock(clock),
		.rst(rst),
		.srMod(srMod),
		.rawOp(rawOp),
		.rejectReq(rejectReq),
		.decOp(decOp)
	);

endmodule

/* rvDecTop_chk.sv */
// decoder port assertions
`include "rvDec_defines.svh"

module rvDecTop_chk (
	input logic clock,
	input logic rst,
	input logic [2:0] srMod,
	input logic [`RV_ISTR_W-1:0] istrWord,
	input rvDecPkg::microOpT decOp
);
	timeunit 1ns;
	timeprecision 100ps;

	resetIdle: assert property (@(posedge clock)
		rst |=> decOp.uCmd.nmid == rvDecPkg::INVOP)
		else $error("major op is not INVOP after reset");

	// user mode may not write the thread pointer
	userTpReject: assert property (@(posedge clock)
		(srMod[0] && istrWord[`RV_RD_LSB +: 5] == `RV_USER_TP)
		|=> decOp.uCmd.nmid == rvDecPkg::INVOP)
		else $error("user-mode write to x4 was not rejected");

	shortWordZzr: assert property (@(posedge clock)
		(istrWord[1:0] != 2'b11)
		|=> (decOp.regN == `RV_GR_ZZR && decOp.regM == `RV_GR_ZZR
			&& decOp.regO == `RV_GR_ZZR && decOp.regP == `RV_GR_ZZR))
		else $error("non 32-bit word left a register other than ZZR");

endmodule

bind rvDecTop rvDecTop_chk u_chk (.*);

/* rvDecTb.sv */
// decoder testbench
`include "rvDec_defines.svh"

module rvDecTb;
	timeunit 1ns;
	timeprecision 100ps;

	// one stimulus line, inputs then expected micro-op fields
	typedef struct packed {
		logic [2:0] srMod;
		rvDecPkg::instrModeT mode;
		logic [`RV_ISTR_W-1:0] word;
		logic [5:0] nmid;
		logic [2:0] ucty;
		logic [5:0] ix;
		logic [`RV_GPR_W-1:0] regN;
		logic [`RV_GPR_W-1:0] regM;
		logic [`RV_GPR_W-1:0] regO;
		logic [`RV_GPR_W-1:0] regP;
		logic [`RV_IMM_W-1:0] imm;
	} vectorT;

	logic clock;
	logic rst;
	logic [2:0] srMod;
	logic [`RV_ISTR_W-1:0] istrWord;
	rvDecPkg::instrModeT mode;
	rvDecPkg::microOpT decOp;

	vectorT vecs[$];
	vectorT idleOp;
	int errCount;
	int checkCount;
	int cycleCount;
	int cycleLimit;

	rvDecTop u_rvDecTop (
		.clock(clock),
		.rst(rst),
		.srMod(srMod),
		.istrWord(istrWord),
		.mode(mode),
		.decOp(decOp)
	);

	always #10 clock = ~clock;

	task automatic loadVectors();
		int fd;
		int n;
		string line;
		logic [2:0] sr;
		logic [1:0] md;
		logic [31:0] w;
		logic [5:0] nm;
		logic [2:0] ct;
		logic [5:0] ix;
		logic [6:0] rn;
		logic [6:0] rm;
		logic [6:0] ro;
		logic [6:0] rp;
		logic [32:0] im;
		vectorT v;
		fd = $fopen("rvDec_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Error: cannot open rvDec_stimulus.txt for reading");
			errCount++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 1 && line[0] != "#") begin // skip blanks and column notes
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
					sr, md, w, nm, ct, ix, rn, rm, ro, rp, im);
				if (n == 11) begin
					v.srMod = sr;
					v.mode = rvDecPkg::instrModeT'(md);
					v.word = w;
					v.nmid = nm;
					v.ucty = ct;
					v.ix = ix;
					v.regN = rn;
					v.regM = rm;
					v.regO = ro;
					v.regP = rp;
					v.imm = im;
					vecs.push_back(v);
				end else begin
					$display("Error: malformed stimulus line: %s", line);
					errCount++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic checkField(input string label, input string name,
		input logic [32:0] got, input logic [32:0] want);
		checkCount++;
		if (got !== want) begin
			errCount++;
			$display("CHECK FAILED at %0t: %s %s got %0h expected %0h",
				$time, label, name, got, want);
		end
	endtask

	task automatic compareOp(input string label, input vectorT want);
		checkField(label, "condition code", 33'(decOp.uCmd.ccty), 33'd0);
		checkField(label, "major op", 33'(decOp.uCmd.nmid), 33'(want.nmid));
		checkField(label, "condition class", 33'(decOp.uIxt.ucty), 33'(want.ucty));
		checkField(label, "sub-op", 33'(decOp.uIxt.ix), 33'(want.ix));
		checkField(label, "regN", 33'(decOp.regN), 33'(want.regN));
		checkField(label, "regM", 33'(decOp.regM), 33'(want.regM));
		checkField(label, "regO", 33'(decOp.regO), 33'(want.regO));
		checkField(label, "regP", 33'(decOp.regP), 33'(want.regP));
		checkField(label, "imm", decOp.imm, want.imm);
		checkField(label, "flags", 33'(decOp.uFl), 33'd0); // flag nibble stays clear
	endtask

	task automatic applyVector(input vectorT v);
		srMod = v.srMod;
		mode = v.mode;
		istrWord = v.word;
	endtask

	initial begin
		clock = 1'b0;
		rst = 1'b1;
		srMod = 3'd0;
		istrWord = '0;
		mode = '0;
		errCount = 0;
		checkCount = 0;
		idleOp = '0;
		idleOp.regN = `RV_GR_ZZR;
		idleOp.regM = `RV_GR_ZZR;
		idleOp.regO = `RV_GR_ZZR;
		idleOp.regP = `RV_GR_ZZR;
		loadVectors();
		if (vecs.size() == 0) begin
			$display("Error: no stimulus vectors were loaded");
			errCount++;
		end
		cycleLimit = vecs.size() + 40;

		repeat (8) @(posedge clock);
		#2;
		rst = 1'b0;
		compareOp("reset", idleOp);

		// a new word every cycle, each result one edge later
		for (int i = 0; i < vecs.size(); i++) begin
			applyVector(vecs[i]);
			@(posedge clock);
			#2;
			compareOp($sformatf("vector %0d", i), vecs[i]);
		end

		$display("checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		cycleCount = 0;
		@(posedge clock);
		while (cycleCount < cycleLimit) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Timeout: run did not finish within %0d cycles", cycleLimit);
		$display("Some tests failed");
		$finish;
	end

endmodule

/* rvDec_stimulus.txt */
# srMod mode word nmid ucty ix regN regM regO regP imm, all hex
# mode is {isRiscV, isWxe}; expected fields are decOp one cycle after the word
0 2 00c58533 06 0 00 0a 0b 0c 0a 00000000c
0 2 407302b3 06 0 01 45 46 47 45 000000407
0 2 4014d433 07 0 12 08 09 41 08 000000401
0 2 014131b3 06 0 05 43 42 14 43 000000014
0 2 ffb80793 06 0 00 0f 10 5e 0f 1fffffffb
0 2 4034d493 07 0 12 09 09 5e 09 000000403
0 2 00e6863b 06 0 02 0c 0d 0e 0c 00000000e
0 2 40c5853b 06 0 03 0a 0b 0c 0a 00000040c
0 2 0079189b 08 0 13 11 12 5e 11 000000007
0 2 016ada3b 08 0 14 14 15 16 14 000000016
0 2 0f0cfc13 06 0 0a 18 19 5e 18 0000000f0
0 2 01eeee33 06 0 09 1c 1d 1e 1c 00000001e
# loads and stores
0 2 01013503 01 0 30 0a 42 5e 0a 000000010
0 2 ffc44583 01 0 04 0b 08 5e 0b 000000ffc
0 2 02057483 01 1 34 09 0a 5e 09 000000020
0 2 02c6b423 02 0 30 0c 0d 5e 0c 000000028
0 2 fe54ac23 02 0 20 45 09 5e 45 1fffffff8
# lui, auipc, jal, jalr
0 2 12345537 0a 0 30 0a 5e 0a 0a 012345000
0 2 fffff0b7 0a 0 30 41 5e 41 41 0fffff000
0 2 00010197 09 0 00 43 40 5e 43 000010000
0 2 100000ef 04 0 00 41 40 5e 41 000000080
0 2 ffdff06f 05 0 00 5f 40 5e 5f 1fffffffe
0 2 008280e7 04 0 00 41 45 5e 41 000000008
0 2 00008067 05 0 00 5f 41 5e 5f 000000000
# branches
0 2 00b50863 03 0 20 5f 0a 0b 5f 000000008
0 2 fe209ce3 03 0 21 5f 41 42 5f 1fffffffc
0 2 0063e263 03 0 24 5f 47 46 5f 000000002
0 2 035a5063 03 0 23 5f 14 15 5f 000000010
0 2 00947463 03 0 25 5f 08 09 5f 000000004
# writes to x4 in user and supervisor mode
1 2 00b50233 00 0 00 44 0a 0b 44 00000000b
0 2 00b50233 06 0 00 44 0a 0b 44 00000000b
1 2 00c58533 06 0 00 0a 0b 0c 0a 00000000c
# short word, RISC-V mode off, wxe set, unknown opcode, then a normal word
0 2 00c58531 00 0 00 5f 5f 5f 5f 000000000
0 0 00c58533 00 0 00 5f 5f 5f 5f 000000000
0 3 00c58533 00 0 00 5f 5f 5f 5f 000000000
0 2 0000000f 00 0 00 5f 5f 5f 5f 000000000
0 2 00c58533 06 0 00 0a 0b 0c 0a 00000000c

/* project.f */
+incdir+.
rvDecPkg.sv
rvRegFieldMap.sv
rvImmGen.sv
rvOpClassify.sv
rvOperandRoute.sv
rvDecodeLatch.sv
rvDecTop.sv
rvDecTop_chk.sv
rvDecTb.sv

/* Makefile */
TOP = rvDecTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f project.f -o rvDecSim
	@out="$$(./obj_dir/rvDecSim)"; echo "$$out"; \
		echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir
